// ==== fifo_asym_top.sv ====
`timescale 1ns/10ps

module fifo_asym_top
  import fifo_geom_pkg::*;
  import fifo_mem_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    w_en_i,
  input  w_word_t w_data_i,
  input  logic    r_en_i,
  output r_byte_t r_data_o,
  output logic    r_empty_o,
  output logic    w_full_o,
  output level_t  level_o
);

  // accepted strobes
  logic w_acc;
  logic r_acc;

  // bank write side
  logic       bank_we;
  bank_addr_t bank_waddr;
  w_word_t    bank_wdata;

  // bank read side
  logic       bank_re;
  bank_addr_t bank_raddr;
  w_word_t    bank_rdata;

  fifo_write_ctrl i_fifo_write_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .w_en_i       (w_en_i),
    .w_full_i     (w_full_o),
    .w_data_i     (w_data_i),
    .w_acc_o      (w_acc),
    .bank_we_o    (bank_we),
    .bank_waddr_o (bank_waddr),
    .bank_wdata_o (bank_wdata)
  );

  fifo_read_ctrl i_fifo_read_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .r_en_i       (r_en_i),
    .r_empty_i    (r_empty_o),
    .bank_rdata_i (bank_rdata),
    .r_acc_o      (r_acc),
    .bank_re_o    (bank_re),
    .bank_raddr_o (bank_raddr),
    .r_data_o     (r_data_o)
  );

  fifo_level_ctrl i_fifo_level_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .w_acc_i   (w_acc),
    .r_acc_i   (r_acc),
    .level_o   (level_o),
    .r_empty_o (r_empty_o),
    .w_full_o  (w_full_o)
  );

  fifo_bank_ram i_fifo_bank_ram (
    .clk_i   (clk_i),
    .we_i    (bank_we),
    .waddr_i (bank_waddr),
    .wdata_i (bank_wdata),
    .re_i    (bank_re),
    .raddr_i (bank_raddr),
    .rdata_o (bank_rdata)
  );

endmodule

// ==== fifo_bank_ram.sv ====
`timescale 1ns/10ps

module fifo_bank_ram
  import fifo_geom_pkg::*;
  import fifo_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       we_i,
  input  bank_addr_t waddr_i,
  input  w_word_t    wdata_i,
  input  logic       re_i,
  input  bank_addr_t raddr_i,
  output w_word_t    rdata_o
);

  // bank k holds byte lane k of every stored word
  r_byte_t mem_q [N_BANKS][2**BANK_AW];
  w_word_t rdata_q;

  // whole word lands in one row across all banks
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int k = 0; k < N_BANKS; k++) begin
        mem_q[k][waddr_i] <= wdata_i[k*R_DATA_W +: R_DATA_W];
      end
    end
  end

  // all banks read at once, lane picked by the reader
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      for (int k = 0; k < N_BANKS; k++) begin
        rdata_q[k*R_DATA_W +: R_DATA_W] <= mem_q[k][raddr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== fifo_geom_pkg.sv ====
package fifo_geom_pkg;

  // port widths
  localparam int W_DATA_W = 32;
  localparam int R_DATA_W = 8;

  // bytes carried by one write word
  localparam int RATIO = W_DATA_W / R_DATA_W;

  // capacity, counted in read-side units
  localparam int DEPTH_B = 64;

  // level must reach DEPTH_B itself, hence the extra bit
  localparam int LEVEL_W = $clog2(DEPTH_B) + 1;

  // write side word
  typedef logic [W_DATA_W-1:0] w_word_t;

  // read side byte
  typedef logic [R_DATA_W-1:0] r_byte_t;

  // fill level in bytes, 0 .. DEPTH_B
  typedef logic [LEVEL_W-1:0] level_t;

endpackage

// ==== fifo_level_ctrl.sv ====
`timescale 1ns/10ps

module fifo_level_ctrl
  import fifo_geom_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   w_acc_i,
  input  logic   r_acc_i,
  output level_t level_o,
  output logic   r_empty_o,
  output logic   w_full_o
);

  level_t level_q;
  level_t level_nxt;
  logic   empty_nxt;
  logic   full_nxt;
  logic   empty_q;
  logic   full_q;

  // a write brings a whole word, a read takes one byte
  always_comb begin
    level_nxt = level_q;
    if (w_acc_i && !r_acc_i) begin
      level_nxt = level_t'(level_q + RATIO);
    end else if (w_acc_i && r_acc_i) begin
      level_nxt = level_t'(level_q + RATIO - 1);  // net +3
    end else if (r_acc_i) begin
      level_nxt = level_t'(level_q - 1'b1);
    end
  end

  // flags follow the next level so they line up with level_o
  assign empty_nxt = level_nxt < level_t'(1);
  assign full_nxt  = level_nxt > level_t'(DEPTH_B - RATIO);  // no room for a word

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end else begin
      level_q <= level_nxt;
      empty_q <= empty_nxt;
      full_q  <= full_nxt;
    end
  end

  assign level_o   = level_q;
  assign r_empty_o = empty_q;
  assign w_full_o  = full_q;

  a_level_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    level_q <= level_t'(DEPTH_B)
  ) else $error("level above depth: %0d", level_q);

  a_flags_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(empty_q && full_q)
  ) else $error("full and empty both set");

endmodule

// ==== fifo_mem_pkg.sv ====
package fifo_mem_pkg;

  // one byte lane per bank
  localparam int N_BANKS = 4;
  localparam int LANE_W = $clog2(N_BANKS);

  // rows per bank, one row holds one write word
  localparam int BANK_AW = 4;

  // full byte address on the read side
  localparam int RD_AW = BANK_AW + LANE_W;

  typedef logic [BANK_AW-1:0] bank_addr_t;  // row index
  typedef logic [LANE_W-1:0] lane_t;  // bank index
  typedef logic [RD_AW-1:0] rd_addr_t;  // {row, lane}

endpackage

// ==== fifo_read_ctrl.sv ====
`timescale 1ns/10ps

module fifo_read_ctrl
  import fifo_geom_pkg::*;
  import fifo_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       r_en_i,
  input  logic       r_empty_i,
  input  w_word_t    bank_rdata_i,
  output logic       r_acc_o,
  output logic       bank_re_o,
  output bank_addr_t bank_raddr_o,
  output r_byte_t    r_data_o
);

  rd_addr_t raddr_q;    // next byte to return
  lane_t    lane_q;     // lane of the read in flight
  logic     pend_q;     // bank word valid this cycle
  r_byte_t  rdata_q;
  r_byte_t  lane_byte;

  // request while empty is dropped
  assign r_acc_o = r_en_i & ~r_empty_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      raddr_q <= '0;
    end else if (r_acc_o) begin
      raddr_q <= rd_addr_t'(raddr_q + 1'b1);
    end
  end

  // row goes to the banks now, lane is kept for the next cycle
  assign bank_re_o    = r_acc_o;
  assign bank_raddr_o = raddr_q[RD_AW-1:LANE_W];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      lane_q <= '0;
    end else begin
      pend_q <= r_acc_o;
      if (r_acc_o) lane_q <= raddr_q[LANE_W-1:0];
    end
  end

  always_comb begin
    lane_byte = '0;
    for (int k = 0; k < N_BANKS; k++) begin
      if (lane_t'(k) == lane_q) lane_byte = bank_rdata_i[k*R_DATA_W +: R_DATA_W];
    end
  end

  // output holds until the next read lands
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (pend_q) begin
      rdata_q <= lane_byte;
    end
  end

  assign r_data_o = rdata_q;

  // a read attempt on an empty FIFO moves nothing and launches nothing
  a_no_read_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (r_en_i && r_empty_i) |=> ($stable(raddr_q) && !pend_q)
  ) else $error("read accepted while empty");

endmodule

// ==== fifo_write_ctrl.sv ====
`timescale 1ns/10ps

module fifo_write_ctrl
  import fifo_geom_pkg::*;
  import fifo_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       w_en_i,
  input  logic       w_full_i,
  input  w_word_t    w_data_i,
  output logic       w_acc_o,
  output logic       bank_we_o,
  output bank_addr_t bank_waddr_o,
  output w_word_t    bank_wdata_o
);

  bank_addr_t waddr_q;  // next row to fill

  // request while full is dropped
  assign w_acc_o = w_en_i & ~w_full_i;

  // row counter, wraps at the bank depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      waddr_q <= '0;
    end else if (w_acc_o) begin
      waddr_q <= bank_addr_t'(waddr_q + 1'b1);
    end
  end

  assign bank_we_o    = w_acc_o;
  assign bank_waddr_o = waddr_q;
  assign bank_wdata_o = w_data_i;  // lanes split inside the banks

  // a write attempt against a full FIFO must leave the row pointer alone
  a_no_write_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (w_en_i && w_full_i) |=> $stable(waddr_q)
  ) else $error("write accepted while full");

endmodule

// ==== files.f ====
fifo_geom_pkg.sv
fifo_mem_pkg.sv
fifo_bank_ram.sv
fifo_write_ctrl.sv
fifo_read_ctrl.sv
fifo_level_ctrl.sv
fifo_asym_top.sv
tb_fifo_asym_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_fifo_asym_top \
  -f files.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== tb_fifo_asym_top.sv ====
`timescale 1ns/10ps

module tb_fifo_asym_top
  import fifo_geom_pkg::*;
;

  typedef struct packed {
    logic       w_en;
    w_word_t    w_data;   // base word, bumped per repeat
    logic       r_en;
    logic [6:0] rep;
    logic [2:0] tag;      // test number
  } stim_t;

  localparam int N_ROWS = 10;

  stim_t stim_tbl [N_ROWS] = '{
    '{1'b0, 32'h0000_0000, 1'b0, 7'd2,  3'd1},
    '{1'b1, 32'h4433_2211, 1'b0, 7'd1,  3'd2},
    '{1'b0, 32'h0000_0000, 1'b1, 7'd4,  3'd2},
    '{1'b1, 32'h8877_6655, 1'b0, 7'd1,  3'd3},
    '{1'b1, 32'hccbb_aa99, 1'b1, 7'd1,  3'd3},  // write and read together
    '{1'b1, 32'hd3c3_b3a3, 1'b0, 7'd16, 3'd4},
    '{1'b1, 32'hdead_beef, 1'b0, 7'd1,  3'd4},  // must be dropped
    '{1'b0, 32'h0000_0000, 1'b1, 7'd64, 3'd4},
    '{1'b0, 32'h0000_0000, 1'b1, 7'd3,  3'd5},
    '{1'b0, 32'h0000_0000, 1'b0, 7'd1,  3'd5}
  };

  string test_name [6] = '{"reset state", "byte order", "write and read together",
                           "full and overflow", "read while empty", "random traffic"};

  logic    clk_i;
  logic    rst_n_i;
  logic    w_en_i;
  w_word_t w_data_i;
  logic    r_en_i;
  r_byte_t r_data_o;
  logic    r_empty_o;
  logic    w_full_o;
  level_t  level_o;

  r_byte_t model_q [$];  // bytes held by the FIFO
  r_byte_t exp_rdata;
  r_byte_t pend_byte;    // byte of the read in flight
  logic    pend_vld;
  logic    timed_out;
  int      err_cnt;
  int      check_cnt;

  fifo_asym_top i_fifo_asym_top (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .w_en_i    (w_en_i),
    .w_data_i  (w_data_i),
    .r_en_i    (r_en_i),
    .r_data_o  (r_data_o),
    .r_empty_o (r_empty_o),
    .w_full_o  (w_full_o),
    .level_o   (level_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_outputs();
    level_t exp_level;
    exp_level = level_t'(model_q.size());
    check_cnt += 4;
    assert (r_data_o == exp_rdata) else begin
      $display("** Error: r_data_o = %h, expected %h at %0t", r_data_o, exp_rdata, $time);
      err_cnt++;
    end
    assert (level_o == exp_level) else begin
      $display("** Error: level_o = %h, expected %h at %0t", level_o, exp_level, $time);
      err_cnt++;
    end
    assert (r_empty_o == (model_q.size() < 1)) else begin
      $display("** Error: r_empty_o = %h, expected %h at %0t",
               r_empty_o, model_q.size() < 1, $time);
      err_cnt++;
    end
    assert (w_full_o == (model_q.size() > DEPTH_B - RATIO)) else begin
      $display("** Error: w_full_o = %h, expected %h at %0t",
               w_full_o, model_q.size() > DEPTH_B - RATIO, $time);
      err_cnt++;
    end
  endtask

  // called just after an edge, returns just after the next one
  task automatic cycle(input logic we, input w_word_t wd, input logic re);
    logic wa;
    logic ra;
    w_en_i   = we;
    w_data_i = wd;
    r_en_i   = re;
    wa = we && (model_q.size() <= DEPTH_B - RATIO);
    ra = re && (model_q.size() >= 1);
    @(posedge clk_i);
    #1;
    if (pend_vld) exp_rdata = pend_byte;  // one cycle read latency
    pend_vld = ra;
    if (ra) pend_byte = model_q.pop_front();
    if (wa) begin
      for (int k = 0; k < RATIO; k++) begin
        model_q.push_back(wd[k*R_DATA_W +: R_DATA_W]);  // low byte first
      end
    end
    check_outputs();
  endtask

  function automatic logic drained();
    return (model_q.size() == 0) && !pend_vld && r_empty_o;
  endfunction

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (!drained() && n < max_cycles) begin
      cycle(1'b0, '0, 1'b1);
      n++;
    end
    w_en_i = 1'b0;
    r_en_i = 1'b0;
    if (!drained()) begin
      $display("timeout: FIFO still holds data after %0d read cycles", max_cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_table_test(input int t);
    if (t == 1) check_outputs();  // state right after reset
    for (int r = 0; r < N_ROWS; r++) begin
      if (stim_tbl[r].tag == 3'(t)) begin
        for (int i = 0; i < int'(stim_tbl[r].rep); i++) begin
          cycle(stim_tbl[r].w_en, w_word_t'(stim_tbl[r].w_data + i * 32'h0101_0101),
                stim_tbl[r].r_en);
        end
      end
    end
    drain(80);
  endtask

  task automatic run_random_test();
    for (int i = 0; i < 300; i++) begin
      cycle(($urandom % 4) == 0, w_word_t'($urandom), ($urandom % 4) != 0);
    end
    drain(80);
  endtask

  initial begin
    int e0;
    int c0;
    void'($urandom(32'hbe4c_5485));
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    w_en_i    = 1'b0;
    w_data_i  = '0;
    r_en_i    = 1'b0;
    exp_rdata = '0;
    pend_byte = '0;
    pend_vld  = 1'b0;
    timed_out = 1'b0;
    err_cnt   = 0;
    check_cnt = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (int t = 1; t <= 6; t++) begin
      e0 = err_cnt;
      c0 = check_cnt;
      if (t < 6) run_table_test(t);
      else run_random_test();
      $display("test %0d %s: %0d checks, %0d errors",
               t, test_name[t-1], check_cnt - c0, err_cnt - e0);
      if (timed_out) break;
    end

    $display("done: %0d checks, %0d errors, timeout %0d", check_cnt, err_cnt, timed_out);
    if (err_cnt == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
